// ==== pdh_settings.svh ====
`ifndef PDH_SETTINGS_SVH
`define PDH_SETTINGS_SVH

//////////////////////////////////////////
// Data widths
//////////////////////////////////////////

`define PDH_ADC_W      14           // Raw ADC sample
`define PDH_DAC_W      14
`define PDH_GPIO_W     32           // Command and callback words
`define PDH_FEED_W     16           // Signed samples, coefficients, feeds

//////////////////////////////////////////
// Command word layout
//////////////////////////////////////////

`define PDH_OP_W       4
`define PDH_PAYLOAD_W  26
`define PDH_LED_W      8
`define PDH_IDX_W      5            // Readback index field

//////////////////////////////////////////
// Datapath constants and reset values
//////////////////////////////////////////

`define PDH_ADC_OFFSET 8192         // Mid-scale of offset binary
`define PDH_COEF_ONE   16'sh7FFF
`define PDH_DAC_MID    14'h2000
`define PDH_ROT_SHIFT  15

`endif

// ==== pdh_pkg.sv ====
`include "pdh_settings.svh"

package pdh_pkg;

    // Opcodes 7 to 15 fall through to the reset branch
    typedef enum logic [`PDH_OP_W-1:0] {
        CMD_IDLE       = 4'd0,
        CMD_SET_LED    = 4'd1,
        CMD_SET_DAC    = 4'd2,
        CMD_GET_ADC    = 4'd3,
        CMD_READBACK   = 4'd4,
        CMD_SET_ROT    = 4'd5,
        CMD_COMMIT_ROT = 4'd6
    } cmd_e;

    //////////////////////////////////////////
    // Payload views
    //////////////////////////////////////////

    typedef struct packed {
        logic [`PDH_PAYLOAD_W-`PDH_LED_W-1:0] pad;
        logic [`PDH_LED_W-1:0]                value;
    } led_view_t;

    typedef struct packed {
        logic [`PDH_PAYLOAD_W-`PDH_DAC_W-2:0] pad;
        logic                                 ch;    // 1 selects channel 2
        logic [`PDH_DAC_W-1:0]                value;
    } dac_view_t;

    typedef struct packed {
        logic [`PDH_PAYLOAD_W-`PDH_FEED_W-2:0] pad;
        logic                                  sin_sel;
        logic signed [`PDH_FEED_W-1:0]         coef;
    } rot_view_t;

    typedef struct packed {
        logic [`PDH_PAYLOAD_W-`PDH_IDX_W-1:0] pad;
        logic [`PDH_IDX_W-1:0]                index;
    } rb_view_t;

    typedef union packed {
        led_view_t led;
        dac_view_t dac;
        rot_view_t rot;
        rb_view_t  rb;
    } cmd_payload_u;

    typedef struct packed {
        logic         rsvd;
        logic         strobe;
        cmd_e         op;
        cmd_payload_u payload;
    } gpio_cmd_t;

    //////////////////////////////////////////
    // Datapath bundles
    //////////////////////////////////////////

    typedef struct packed {
        logic [`PDH_ADC_W-1:0] a;
        logic [`PDH_ADC_W-1:0] b;
    } adc_pair_t;

    typedef struct packed {
        logic signed [`PDH_FEED_W-1:0] first;   // Sample a or I
        logic signed [`PDH_FEED_W-1:0] second;  // Sample b or Q
    } iq_pair_t;

    typedef struct packed {
        logic signed [`PDH_FEED_W-1:0] cos;
        logic signed [`PDH_FEED_W-1:0] sin;
    } rot_coef_t;

    typedef struct packed {
        logic [`PDH_DAC_W-1:0] ch1;
        logic [`PDH_DAC_W-1:0] ch2;
    } dac_pair_t;

endpackage

// ==== ps_cmd_sync.sv ====
`include "pdh_settings.svh"

module ps_cmd_sync (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`PDH_GPIO_W-1:0] gpio_i,
    output pdh_pkg::gpio_cmd_t     cmd_o
);

    pdh_pkg::gpio_cmd_t gpio_w;
    logic               strobe_meta_r;
    logic               strobe_sync_r;
    logic               strobe_prev_r;
    logic               strobe_edge_w;
    pdh_pkg::gpio_cmd_t cmd_r;

    assign gpio_w = pdh_pkg::gpio_cmd_t'(gpio_i);

    //////////////////////////////////////////
    // Strobe synchronizer and edge detect
    //////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            strobe_meta_r <= 1'b0;
            strobe_sync_r <= 1'b0;
            strobe_prev_r <= 1'b0;
        end else begin
            strobe_meta_r <= gpio_w.strobe;
            strobe_sync_r <= strobe_meta_r;
            strobe_prev_r <= strobe_sync_r;
        end
    end

    assign strobe_edge_w = strobe_sync_r & ~strobe_prev_r;

    // Word is stable around the strobe, so it is taken straight from the pins
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            cmd_r <= '0;                 // Opcode idle
        end else if (strobe_edge_w) begin
            cmd_r <= gpio_w;
        end
    end

    assign cmd_o = cmd_r;

endmodule

// ==== pdh_ctrl_regs.sv ====
`include "pdh_settings.svh"

module pdh_ctrl_regs (
    input  logic                   clk,
    input  logic                   rst_i,
    input  pdh_pkg::gpio_cmd_t     cmd_i,
    input  pdh_pkg::adc_pair_t     adc_i,
    input  pdh_pkg::iq_pair_t      samples_i,
    input  pdh_pkg::iq_pair_t      feeds_i,
    output pdh_pkg::rot_coef_t     coef_o,
    output pdh_pkg::dac_pair_t     dac_o,
    output logic [`PDH_LED_W-1:0]  led_o,
    output logic [`PDH_GPIO_W-1:0] gpio_o
);

    localparam int unsigned LED_PAD = `PDH_GPIO_W - `PDH_OP_W - `PDH_LED_W;
    localparam int unsigned RB_PAD  = `PDH_GPIO_W - `PDH_OP_W - `PDH_IDX_W - `PDH_FEED_W;

    localparam pdh_pkg::rot_coef_t COEF_RST = '{cos: `PDH_COEF_ONE, sin: '0};
    localparam pdh_pkg::dac_pair_t DAC_RST  = '{ch1: `PDH_DAC_MID, ch2: `PDH_DAC_MID};

    logic [`PDH_LED_W-1:0]  led_r, led_nxt;
    pdh_pkg::rot_coef_t     stage_r, stage_nxt;
    pdh_pkg::rot_coef_t     coef_r, coef_nxt;
    pdh_pkg::dac_pair_t     dac_r, dac_nxt;
    logic [`PDH_GPIO_W-1:0] cb_r, cb_nxt;
    logic [`PDH_OP_W-1:0]   op_w;
    pdh_pkg::cmd_payload_u  pl_w;
    logic [`PDH_FEED_W-1:0] rb_val_w;

    assign op_w = cmd_i.op;
    assign pl_w = cmd_i.payload;

    //////////////////////////////////////////
    // Readback select
    //////////////////////////////////////////

    always_comb begin
        case (pl_w.rb.index)
            5'd0:    rb_val_w = samples_i.first;
            5'd1:    rb_val_w = samples_i.second;
            5'd2:    rb_val_w = stage_r.cos;
            5'd3:    rb_val_w = stage_r.sin;
            5'd4:    rb_val_w = coef_r.cos;
            5'd5:    rb_val_w = coef_r.sin;
            5'd6:    rb_val_w = feeds_i.first;      // I
            5'd7:    rb_val_w = feeds_i.second;     // Q
            default: rb_val_w = '0;
        endcase
    end

    //////////////////////////////////////////
    // Command decode
    //////////////////////////////////////////

    always_comb begin
        led_nxt   = led_r;
        stage_nxt = stage_r;
        coef_nxt  = coef_r;
        dac_nxt   = dac_r;
        cb_nxt    = '0;
        case (cmd_i.op)
            pdh_pkg::CMD_IDLE: begin
                cb_nxt = '0;
            end
            pdh_pkg::CMD_SET_LED: begin
                led_nxt = pl_w.led.value;
                cb_nxt  = {op_w, {LED_PAD{1'b0}}, led_r};
            end
            pdh_pkg::CMD_SET_DAC: begin
                if (pl_w.dac.ch) begin
                    dac_nxt.ch2 = pl_w.dac.value;
                end else begin
                    dac_nxt.ch1 = pl_w.dac.value;
                end
                cb_nxt = {op_w, dac_r.ch1, dac_r.ch2};
            end
            pdh_pkg::CMD_GET_ADC: begin
                cb_nxt = {op_w, adc_i.b, adc_i.a};
            end
            pdh_pkg::CMD_READBACK: begin
                cb_nxt = {op_w, {RB_PAD{1'b0}}, pl_w.rb.index, rb_val_w};
            end
            pdh_pkg::CMD_SET_ROT: begin
                if (pl_w.rot.sin_sel) begin
                    stage_nxt.sin = pl_w.rot.coef;
                end else begin
                    stage_nxt.cos = pl_w.rot.coef;
                end
                cb_nxt = {op_w, stage_r.sin[`PDH_FEED_W-1:2], stage_r.cos[`PDH_FEED_W-1:2]};
            end
            pdh_pkg::CMD_COMMIT_ROT: begin
                coef_nxt = stage_r;
                cb_nxt   = {op_w, feeds_i.second[`PDH_FEED_W-1:2],
                            feeds_i.first[`PDH_FEED_W-1:2]};
            end
            default: begin                          // Unknown opcode acts as soft reset
                led_nxt   = '0;
                stage_nxt = COEF_RST;
                coef_nxt  = COEF_RST;
                dac_nxt   = DAC_RST;
                cb_nxt    = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            led_r   <= '0;
            stage_r <= COEF_RST;
            coef_r  <= COEF_RST;
            dac_r   <= DAC_RST;
            cb_r    <= '0;
        end else begin
            led_r   <= led_nxt;
            stage_r <= stage_nxt;
            coef_r  <= coef_nxt;
            dac_r   <= dac_nxt;
            cb_r    <= cb_nxt;                      // Refreshed every cycle
        end
    end

    assign coef_o = coef_r;
    assign dac_o  = dac_r;
    assign led_o  = led_r;
    assign gpio_o = cb_r;

endmodule

// ==== iq_rotator.sv ====
`include "pdh_settings.svh"

module iq_rotator (
    input  logic               clk,
    input  logic               rst_i,
    input  pdh_pkg::adc_pair_t adc_i,
    input  pdh_pkg::rot_coef_t coef_i,
    output pdh_pkg::iq_pair_t  samples_o,
    output pdh_pkg::iq_pair_t  feeds_o
);

    localparam int unsigned FEED_W = `PDH_FEED_W;
    localparam int unsigned PROD_W = 2 * FEED_W;
    localparam logic signed [`PDH_ADC_W:0] ADC_OFFSET = `PDH_ADC_OFFSET;

    pdh_pkg::iq_pair_t              samples_r;
    pdh_pkg::iq_pair_t              feeds_r;
    logic signed [PROD_W:0]         i_sum_w;
    logic signed [PROD_W:0]         q_sum_w;

    // Offset binary to negated two's complement
    function automatic logic signed [FEED_W-1:0] adc_to_feed(input logic [`PDH_ADC_W-1:0] raw);
        logic signed [`PDH_ADC_W:0] diff;
        diff = ADC_OFFSET - $signed({1'b0, raw});
        return FEED_W'(diff);
    endfunction

    // Clamp to 32 signed bits, then scale down
    function automatic logic signed [FEED_W-1:0] sat_shift(input logic signed [PROD_W:0] v);
        logic signed [PROD_W-1:0] sat;
        if (v[PROD_W] != v[PROD_W-1]) begin
            sat = v[PROD_W] ? {1'b1, {(PROD_W-1){1'b0}}} : {1'b0, {(PROD_W-1){1'b1}}};
        end else begin
            sat = v[PROD_W-1:0];
        end
        return FEED_W'(sat >>> `PDH_ROT_SHIFT);
    endfunction

    //////////////////////////////////////////
    // Sample conversion
    //////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            samples_r <= '0;
        end else begin
            samples_r.first  <= adc_to_feed(adc_i.a);
            samples_r.second <= adc_to_feed(adc_i.b);
        end
    end

    //////////////////////////////////////////
    // IQ rotation
    //////////////////////////////////////////

    always_comb begin
        i_sum_w = coef_i.cos * samples_r.first - coef_i.sin * samples_r.second;
        q_sum_w = coef_i.sin * samples_r.first + coef_i.cos * samples_r.second;
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            feeds_r <= '0;
        end else begin
            feeds_r.first  <= sat_shift(i_sum_w);   // I
            feeds_r.second <= sat_shift(q_sum_w);   // Q
        end
    end

    assign samples_o = samples_r;
    assign feeds_o   = feeds_r;

endmodule

// ==== dac_interleaver.sv ====
`include "pdh_settings.svh"

module dac_interleaver (
    input  logic                  clk,
    input  logic                  rst_i,
    input  pdh_pkg::dac_pair_t    dac_i,
    output logic                  dac_sel_o,
    output logic [`PDH_DAC_W-1:0] dac_dat_o
);

    logic sel_r;

    //////////////////////////////////////////
    // Channel select
    //////////////////////////////////////////

    // Alternates each cycle for the dual-channel DAC
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            sel_r <= 1'b0;
        end else begin
            sel_r <= ~sel_r;
        end
    end

    assign dac_sel_o = sel_r;
    assign dac_dat_o = sel_r ? dac_i.ch2 : dac_i.ch1;  // High shows channel 2

endmodule

// ==== pdh_core.sv ====
`include "pdh_settings.svh"

module pdh_core (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`PDH_ADC_W-1:0]  adc_dat_a_i,
    input  logic [`PDH_ADC_W-1:0]  adc_dat_b_i,
    input  logic [`PDH_GPIO_W-1:0] gpio_i,
    output logic [`PDH_GPIO_W-1:0] gpio_o,
    output logic [`PDH_LED_W-1:0]  led_o,
    output logic                   dac_sel_o,
    output logic [`PDH_DAC_W-1:0]  dac_dat_o
);

    pdh_pkg::adc_pair_t adc_w;
    pdh_pkg::gpio_cmd_t cmd_w;
    pdh_pkg::rot_coef_t coef_w;
    pdh_pkg::iq_pair_t  samples_w;
    pdh_pkg::iq_pair_t  feeds_w;
    pdh_pkg::dac_pair_t dac_w;

    assign adc_w.a = adc_dat_a_i;
    assign adc_w.b = adc_dat_b_i;

    //////////////////////////////////////////
    // Command path
    //////////////////////////////////////////

    ps_cmd_sync u_cmd_sync (
        .clk   (clk),
        .rst_i (rst_i),
        .gpio_i(gpio_i),
        .cmd_o (cmd_w)
    );

    pdh_ctrl_regs u_ctrl_regs (
        .clk      (clk),
        .rst_i    (rst_i),
        .cmd_i    (cmd_w),
        .adc_i    (adc_w),
        .samples_i(samples_w),
        .feeds_i  (feeds_w),
        .coef_o   (coef_w),
        .dac_o    (dac_w),
        .led_o    (led_o),
        .gpio_o   (gpio_o)
    );

    //////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////

    iq_rotator u_iq_rotator (
        .clk      (clk),
        .rst_i    (rst_i),
        .adc_i    (adc_w),
        .coef_i   (coef_w),
        .samples_o(samples_w),
        .feeds_o  (feeds_w)
    );

    dac_interleaver u_dac_interleaver (
        .clk      (clk),
        .rst_i    (rst_i),
        .dac_i    (dac_w),
        .dac_sel_o(dac_sel_o),
        .dac_dat_o(dac_dat_o)
    );

endmodule

// ==== tb_pdh_core.sv ====
`include "pdh_settings.svh"

module tb_pdh_core;

    localparam int     NUM_ROWS   = 27;
    localparam int     MAX_CYCLES = NUM_ROWS * 12 + 50;
    localparam longint SAT_MAX    = 64'sd2147483647;
    localparam longint SAT_MIN    = -SAT_MAX - 1;

    typedef enum logic [1:0] {CHK_CB, CHK_LED, CHK_DAC, CHK_ALL} chk_e;

    typedef struct {
        pdh_pkg::gpio_cmd_t cmd;
        pdh_pkg::adc_pair_t adc;
        chk_e               kind;   // Callback is always checked
    } stim_row_t;

    logic                   clk;
    logic                   rst_i;
    logic [`PDH_ADC_W-1:0]  adc_dat_a_i;
    logic [`PDH_ADC_W-1:0]  adc_dat_b_i;
    logic [`PDH_GPIO_W-1:0] gpio_i;
    logic [`PDH_GPIO_W-1:0] gpio_o;
    logic [`PDH_LED_W-1:0]  led_o;
    logic                   dac_sel_o;
    logic [`PDH_DAC_W-1:0]  dac_dat_o;

    stim_row_t             stim [NUM_ROWS];
    int                    row_cnt;
    int                    cycle_cnt;
    logic [31:0]           lfsr_state;
    pdh_pkg::adc_pair_t    adc_cur;
    logic [`PDH_LED_W-1:0] m_led;      // Reference model state
    pdh_pkg::rot_coef_t    m_stage;
    pdh_pkg::rot_coef_t    m_coef;
    pdh_pkg::dac_pair_t    m_dac;

    pdh_core DUT (
        .clk        (clk),
        .rst_i      (rst_i),
        .adc_dat_a_i(adc_dat_a_i),
        .adc_dat_b_i(adc_dat_b_i),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o),
        .led_o      (led_o),
        .dac_sel_o  (dac_sel_o),
        .dac_dat_o  (dac_dat_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_failed();
        end
    end

    //////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic pdh_pkg::gpio_cmd_t make_cmd(input logic [`PDH_OP_W-1:0] op,
                                                     input logic [`PDH_PAYLOAD_W-1:0] pl);
        return pdh_pkg::gpio_cmd_t'({2'b00, op, pl});
    endfunction

    task automatic add_row(input pdh_pkg::gpio_cmd_t cmd, input bit new_adc, input chk_e kind);
        logic [31:0] r;
        if (new_adc) begin
            draw_bits(`PDH_ADC_W, r);
            adc_cur.a = r[`PDH_ADC_W-1:0];
            draw_bits(`PDH_ADC_W, r);
            adc_cur.b = r[`PDH_ADC_W-1:0];
        end
        stim[row_cnt].cmd  = cmd;
        stim[row_cnt].adc  = adc_cur;
        stim[row_cnt].kind = kind;
        row_cnt++;
    endtask

    task automatic build_table();
        int idx;
        add_row(make_cmd(pdh_pkg::CMD_SET_LED, 26'h00000A5), 1'b1, CHK_LED);
        add_row(make_cmd(pdh_pkg::CMD_GET_ADC, 26'h0), 1'b1, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_SET_LED, 26'h000003C), 1'b0, CHK_LED);
        add_row(make_cmd(pdh_pkg::CMD_SET_DAC, {11'h0, 1'b0, 14'h0123}), 1'b1, CHK_DAC);
        add_row(make_cmd(pdh_pkg::CMD_SET_DAC, {11'h0, 1'b1, 14'h3ABC}), 1'b0, CHK_DAC);
        add_row(make_cmd(pdh_pkg::CMD_GET_ADC, 26'h0), 1'b1, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_SET_ROT, {9'h0, 1'b0, 16'h5A82}), 1'b1, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_SET_ROT, {9'h0, 1'b1, 16'hA57E}), 1'b0, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_COMMIT_ROT, 26'h0), 1'b0, CHK_CB);
        for (idx = 0; idx < 8; idx++) begin               // ADC held for all eight
            add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'(idx)), 1'b0, CHK_CB);
        end
        add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'd13), 1'b0, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_SET_ROT, {9'h0, 1'b0, 16'h7000}), 1'b1, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'd2), 1'b0, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'd4), 1'b0, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_COMMIT_ROT, 26'h0), 1'b1, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'd7), 1'b0, CHK_CB);
        add_row(make_cmd(4'hB, 26'h2AA_AAAA), 1'b1, CHK_ALL); // Undefined opcode
        add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'd4), 1'b0, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_READBACK, 26'd6), 1'b1, CHK_CB);
        add_row(make_cmd(pdh_pkg::CMD_IDLE, 26'h0), 1'b0, CHK_ALL);
    endtask

    //////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////

    task automatic reset_model();
        m_led   = '0;
        m_stage = '{cos: `PDH_COEF_ONE, sin: '0};
        m_coef  = m_stage;
        m_dac   = '{ch1: `PDH_DAC_MID, ch2: `PDH_DAC_MID};
    endtask

    task automatic update_model(input pdh_pkg::gpio_cmd_t c);
        case (c.op)
            pdh_pkg::CMD_IDLE, pdh_pkg::CMD_GET_ADC, pdh_pkg::CMD_READBACK: begin
            end
            pdh_pkg::CMD_SET_LED: m_led = c.payload.led.value;
            pdh_pkg::CMD_SET_DAC: begin
                if (c.payload.dac.ch) m_dac.ch2 = c.payload.dac.value;
                else m_dac.ch1 = c.payload.dac.value;
            end
            pdh_pkg::CMD_SET_ROT: begin
                if (c.payload.rot.sin_sel) m_stage.sin = c.payload.rot.coef;
                else m_stage.cos = c.payload.rot.coef;
            end
            pdh_pkg::CMD_COMMIT_ROT: m_coef = m_stage;
            default: reset_model();
        endcase
    endtask

    // Offset binary to negated signed value
    function automatic logic signed [`PDH_FEED_W-1:0] to_feed(input logic [`PDH_ADC_W-1:0] raw);
        int v;
        v = `PDH_ADC_OFFSET - int'(raw);
        return v[`PDH_FEED_W-1:0];
    endfunction

    function automatic logic signed [`PDH_FEED_W-1:0] rotate(input pdh_pkg::rot_coef_t k,
                                                             input pdh_pkg::adc_pair_t adc,
                                                             input bit q_side);
        longint sa;
        longint sb;
        longint p;
        sa = longint'(to_feed(adc.a));
        sb = longint'(to_feed(adc.b));
        p  = q_side ? longint'($signed(k.sin)) * sa + longint'($signed(k.cos)) * sb
                    : longint'($signed(k.cos)) * sa - longint'($signed(k.sin)) * sb;
        p  = (p > SAT_MAX) ? SAT_MAX : ((p < SAT_MIN) ? SAT_MIN : p);
        p  = p >>> `PDH_ROT_SHIFT;
        return p[`PDH_FEED_W-1:0];
    endfunction

    function automatic logic [`PDH_GPIO_W-1:0] expected_cb(input pdh_pkg::gpio_cmd_t c,
                                                           input pdh_pkg::adc_pair_t adc);
        logic [`PDH_OP_W-1:0]   op;
        logic [`PDH_FEED_W-1:0] i_val;
        logic [`PDH_FEED_W-1:0] q_val;
        logic [`PDH_FEED_W-1:0] rb;
        op    = c.op;
        i_val = rotate(m_coef, adc, 1'b0);
        q_val = rotate(m_coef, adc, 1'b1);
        case (c.payload.rb.index)
            5'd0:    rb = to_feed(adc.a);
            5'd1:    rb = to_feed(adc.b);
            5'd2:    rb = m_stage.cos;
            5'd3:    rb = m_stage.sin;
            5'd4:    rb = m_coef.cos;
            5'd5:    rb = m_coef.sin;
            5'd6:    rb = i_val;
            5'd7:    rb = q_val;
            default: rb = '0;
        endcase
        case (c.op)
            pdh_pkg::CMD_SET_LED:    return {op, 20'h0, m_led};
            pdh_pkg::CMD_SET_DAC:    return {op, m_dac.ch1, m_dac.ch2};
            pdh_pkg::CMD_GET_ADC:    return {op, adc.b, adc.a};
            pdh_pkg::CMD_READBACK:   return {op, 7'h0, c.payload.rb.index, rb};
            pdh_pkg::CMD_SET_ROT:    return {op, m_stage.sin[15:2], m_stage.cos[15:2]};
            pdh_pkg::CMD_COMMIT_ROT: return {op, q_val[15:2], i_val[15:2]};
            default:                 return '0;     // Idle and undefined opcodes
        endcase
    endfunction

    //////////////////////////////////////////
    // Checks
    //////////////////////////////////////////

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_callback(input logic [`PDH_GPIO_W-1:0] got, exp, input string tag);
        if (got !== exp) begin
            $display("Mismatch gpio_o (%s): got 0x%h, expected 0x%h", tag, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_led(input logic [`PDH_LED_W-1:0] got, exp, input string tag);
        if (got !== exp) begin
            $display("Mismatch led_o (%s): got 0x%h, expected 0x%h", tag, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_dac_pair(input pdh_pkg::dac_pair_t got, exp, input string tag);
        if (got !== exp) begin
            $display("Mismatch dac_dat_o ch1/ch2 (%s): got 0x%h/0x%h, expected 0x%h/0x%h",
                     tag, got.ch1, got.ch2, exp.ch1, exp.ch2);
            stop_failed();
        end
    endtask

    // Two falling edges see both channels of the bus
    task automatic observe_dac(output pdh_pkg::dac_pair_t seen);
        logic first_sel;
        @(negedge clk);
        first_sel = dac_sel_o;
        if (first_sel) seen.ch2 = dac_dat_o;
        else seen.ch1 = dac_dat_o;
        @(negedge clk);
        if (dac_sel_o === first_sel) begin
            $display("dac_sel_o did not toggle from one cycle to the next");
            stop_failed();
        end
        if (dac_sel_o) seen.ch2 = dac_dat_o;
        else seen.ch1 = dac_dat_o;
    endtask

    //////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////

    initial begin
        pdh_pkg::gpio_cmd_t word;
        pdh_pkg::dac_pair_t seen;
        string              tag;
        int                 r;
        clk         = 1'b0;
        rst_i       = 1'b1;
        gpio_i      = '0;
        adc_dat_a_i = '0;
        adc_dat_b_i = '0;
        cycle_cnt   = 0;
        row_cnt     = 0;
        lfsr_state  = 32'ha6b9_f1a0;
        adc_cur     = '0;
        build_table();
        if (row_cnt != NUM_ROWS) begin
            $display("Stimulus table holds %0d rows instead of %0d", row_cnt, NUM_ROWS);
            stop_failed();
        end
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (dac_sel_o !== 1'b0) begin
            $display("dac_sel_o is not low while reset is held");
            stop_failed();
        end
        @(posedge clk);
        rst_i <= 1'b0;                     // Four cycles of reset
        @(negedge clk);
        check_callback(gpio_o, '0, "after reset");
        check_led(led_o, '0, "after reset");
        observe_dac(seen);
        check_dac_pair(seen, m_dac, "after reset");

        for (r = 0; r < NUM_ROWS; r++) begin
            word        = stim[r].cmd;
            word.strobe = 1'b1;
            @(posedge clk);
            gpio_i      <= word;
            adc_dat_a_i <= stim[r].adc.a;
            adc_dat_b_i <= stim[r].adc.b;
            update_model(stim[r].cmd);
            repeat (8) @(posedge clk);
            word.strobe = 1'b0;
            gpio_i      <= word;
            repeat (2) @(posedge clk);
            @(negedge clk);
            tag = $sformatf("row %0d", r);
            check_callback(gpio_o, expected_cb(stim[r].cmd, stim[r].adc), tag);
            if (stim[r].kind == CHK_LED || stim[r].kind == CHK_ALL) begin
                check_led(led_o, m_led, tag);
            end
            if (stim[r].kind == CHK_DAC || stim[r].kind == CHK_ALL) begin
                observe_dac(seen);
                check_dac_pair(seen, m_dac, tag);
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
pdh_pkg.sv
ps_cmd_sync.sv
pdh_ctrl_regs.sv
iq_rotator.sv
dac_interleaver.sv
pdh_core.sv
tb_pdh_core.sv

// ==== Makefile ====
# Verilator flow for the PDH command and readback core
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_pdh_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
